//--- design/mem_bus_pkg.sv
package mem_bus_pkg;

    // read address channel, single-beat incrementing reads only
    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } axi_r_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [3:0] id;
        logic [1:0] resp;
    } axi_b_t;

    // one word access from the data port of the core
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } data_req_t;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_addr,
        fetch_data,
        fetch_repair  // re-issue after a cancelled read returned
    } fetch_state_e;

    typedef enum logic [2:0] {
        data_idle,
        data_raddr,
        data_rdata,
        data_waddr,
        data_wresp,
        data_done
    } data_state_e;

endpackage

//--- design/inst_fetch_master.sv
`timescale 1ns/1ps

module inst_fetch_master #(
    parameter logic [3:0] INST_ID = 4'd0
) (
    input  logic                axi4_master,
    input  logic                rst,
    input  logic                fetch_en,
    input  logic [31:0]         fetch_addr,
    input  logic                fetch_cancel,
    output logic                fetch_valid,
    output logic [31:0]         fetch_data,
    output mem_bus_pkg::axi_ar_t ar,
    output logic                arvalid,
    input  logic                arready,
    input  mem_bus_pkg::axi_r_t  r,
    input  logic                rvalid,
    output logic                rready
);

    mem_bus_pkg::fetch_state_e state_q;
    logic [31:0] addr_q;
    logic        cancel_q;
    logic        capture;
    logic        r_fire;
    logic        cancelled;

    // while fetch_valid is high the core still holds the old request
    assign capture = ((state_q == mem_bus_pkg::fetch_idle) && fetch_en && !fetch_valid) ||
                     ((state_q == mem_bus_pkg::fetch_repair) && fetch_en);

    assign r_fire    = rvalid && rready;
    assign cancelled = cancel_q || fetch_cancel;  // a cancel on the beat cycle still counts

    assign ar      = '{id: INST_ID, addr: addr_q};
    assign arvalid = (state_q == mem_bus_pkg::fetch_addr);
    assign rready  = (state_q == mem_bus_pkg::fetch_data);

    always_ff @(posedge axi4_master) begin
        if (rst) begin
            state_q     <= mem_bus_pkg::fetch_idle;
            cancel_q    <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= 1'b0;
            case (state_q)
                mem_bus_pkg::fetch_idle: begin
                    if (capture) begin
                        state_q <= mem_bus_pkg::fetch_addr;
                    end
                end
                mem_bus_pkg::fetch_addr: begin
                    if (arready) begin
                        state_q <= mem_bus_pkg::fetch_data;
                    end
                end
                mem_bus_pkg::fetch_data: begin
                    if (r_fire) begin
                        if (cancelled) begin
                            state_q <= mem_bus_pkg::fetch_repair;  // drop the stale word
                        end else begin
                            fetch_valid <= 1'b1;
                            state_q     <= mem_bus_pkg::fetch_idle;
                        end
                    end
                end
                mem_bus_pkg::fetch_repair: begin
                    state_q <= fetch_en ? mem_bus_pkg::fetch_addr : mem_bus_pkg::fetch_idle;
                end
                default: state_q <= mem_bus_pkg::fetch_idle;
            endcase

            if (capture) begin
                cancel_q <= 1'b0;
            end else if (fetch_cancel && (state_q != mem_bus_pkg::fetch_idle)) begin
                cancel_q <= 1'b1;  // only a read in flight can be cancelled
            end
        end
    end

    always_ff @(posedge axi4_master) begin
        if (capture) begin
            addr_q <= fetch_addr;
        end
        if (r_fire && !cancelled) begin
            fetch_data <= r.data;
        end
    end

endmodule

//--- design/data_access_master.sv
`timescale 1ns/1ps

module data_access_master #(
    parameter logic [3:0] DATA_ID = 4'd1
) (
    input  logic                  axi4_master,
    input  logic                  rst,
    input  logic                  data_en,
    input  mem_bus_pkg::data_req_t data_req,
    output logic                  data_done,
    output logic [31:0]           data_rdata,
    output mem_bus_pkg::axi_ar_t   ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  mem_bus_pkg::axi_r_t    r,
    input  logic                  rvalid,
    output logic                  rready,
    output mem_bus_pkg::axi_aw_t   aw,
    output logic                  awvalid,
    input  logic                  awready,
    output mem_bus_pkg::axi_w_t    w,
    output logic                  wvalid,
    input  logic                  wready,
    input  mem_bus_pkg::axi_b_t    b,
    input  logic                  bvalid,
    output logic                  bready
);

    mem_bus_pkg::data_state_e state_q;
    mem_bus_pkg::data_req_t   req_q;
    logic aw_done_q;
    logic w_done_q;
    logic aw_fire;
    logic w_fire;
    logic r_fire;
    logic b_fire;
    logic capture;
    logic aw_seen;
    logic w_seen;

    assign capture = (state_q == mem_bus_pkg::data_idle) && data_en;

    assign ar      = '{id: DATA_ID, addr: req_q.addr};
    assign aw      = '{id: DATA_ID, addr: req_q.addr};
    assign w       = '{data: req_q.wdata, strb: req_q.wstrb, last: 1'b1};

    assign arvalid = (state_q == mem_bus_pkg::data_raddr);
    assign rready  = (state_q == mem_bus_pkg::data_rdata);
    assign awvalid = (state_q == mem_bus_pkg::data_waddr) && !aw_done_q;
    assign wvalid  = (state_q == mem_bus_pkg::data_waddr) && !w_done_q;
    assign bready  = (state_q == mem_bus_pkg::data_wresp);

    assign data_done = (state_q == mem_bus_pkg::data_done);

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign r_fire  = rvalid && rready;
    assign b_fire  = bvalid && bready && (b.id == DATA_ID);  // writes only come from here

    // either channel may be accepted first, or both on the same edge
    assign aw_seen = aw_done_q || aw_fire;
    assign w_seen  = w_done_q || w_fire;

    always_ff @(posedge axi4_master) begin
        if (rst) begin
            state_q   <= mem_bus_pkg::data_idle;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            case (state_q)
                mem_bus_pkg::data_idle: begin
                    if (capture) begin
                        state_q <= data_req.we ? mem_bus_pkg::data_waddr
                                               : mem_bus_pkg::data_raddr;
                    end
                end
                mem_bus_pkg::data_raddr: begin
                    if (arready) begin
                        state_q <= mem_bus_pkg::data_rdata;
                    end
                end
                mem_bus_pkg::data_rdata: begin
                    if (r_fire) begin
                        state_q <= mem_bus_pkg::data_done;
                    end
                end
                mem_bus_pkg::data_waddr: begin
                    if (aw_seen && w_seen) begin
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                        state_q   <= mem_bus_pkg::data_wresp;
                    end else begin
                        aw_done_q <= aw_seen;
                        w_done_q  <= w_seen;
                    end
                end
                mem_bus_pkg::data_wresp: begin
                    if (b_fire) begin
                        state_q <= mem_bus_pkg::data_done;
                    end
                end
                mem_bus_pkg::data_done: begin
                    state_q <= mem_bus_pkg::data_idle;  // lets the core drop data_en first
                end
                default: state_q <= mem_bus_pkg::data_idle;
            endcase
        end
    end

    always_ff @(posedge axi4_master) begin
        if (capture) begin
            req_q <= data_req;
        end
        if (r_fire) begin
            data_rdata <= r.data;
        end
    end

endmodule

//--- design/axi_read_arbiter.sv
`timescale 1ns/1ps

module axi_read_arbiter #(
    parameter logic [3:0] INST_ID = 4'd0,
    parameter logic [3:0] DATA_ID = 4'd1
) (
    input  logic                axi4_master,
    input  logic                rst,
    input  mem_bus_pkg::axi_ar_t inst_ar,
    input  logic                inst_arvalid,
    output logic                inst_arready,
    input  mem_bus_pkg::axi_ar_t data_ar,
    input  logic                data_arvalid,
    output logic                data_arready,
    output mem_bus_pkg::axi_ar_t m_ar,
    output logic                m_arvalid,
    input  logic                m_arready,
    input  logic                inst_rready,
    input  logic                data_rready,
    input  logic                m_rvalid,
    input  mem_bus_pkg::axi_r_t  m_r,
    output logic                m_rready,
    output logic                inst_rvalid,
    output logic                data_rvalid
);

    logic prefer_data_q;
    logic lock_q;
    logic lock_data_q;
    logic sel_data;
    logic r_to_inst;
    logic r_to_data;

    always_comb begin
        if (lock_q) begin
            sel_data = lock_data_q;
        end else if (inst_arvalid && data_arvalid) begin
            sel_data = prefer_data_q;
        end else begin
            sel_data = data_arvalid;
        end
    end

    assign m_ar         = sel_data ? data_ar : inst_ar;
    assign m_arvalid    = sel_data ? data_arvalid : inst_arvalid;
    assign inst_arready = !sel_data && m_arready;
    assign data_arready = sel_data && m_arready;

    always_ff @(posedge axi4_master) begin
        if (rst) begin
            prefer_data_q <= 1'b0;
            lock_q        <= 1'b0;
            lock_data_q   <= 1'b0;
        end else if (m_arvalid) begin
            if (m_arready) begin
                lock_q        <= 1'b0;
                prefer_data_q <= !sel_data;  // the other side wins the next tie
            end else begin
                lock_q      <= 1'b1;  // hold the grant while the slave stalls
                lock_data_q <= sel_data;
            end
        end
    end

    // return path is steered purely by the beat id
    assign r_to_inst   = (m_r.id == INST_ID);
    assign r_to_data   = (m_r.id == DATA_ID);
    assign inst_rvalid = m_rvalid && r_to_inst;
    assign data_rvalid = m_rvalid && r_to_data;
    assign m_rready    = (r_to_inst && inst_rready) || (r_to_data && data_rready);

endmodule

//--- design/mem_bus_top.sv
`timescale 1ns/1ps

module mem_bus_top #(
    parameter logic [3:0] INST_ID = 4'd0,
    parameter logic [3:0] DATA_ID = 4'd1
) (
    input  logic                  axi4_master,
    input  logic                  rst,
    input  logic                  fetch_en,
    input  logic [31:0]           fetch_addr,
    input  logic                  fetch_cancel,
    output logic                  fetch_valid,
    output logic [31:0]           fetch_data,
    input  logic                  data_en,
    input  mem_bus_pkg::data_req_t data_req,
    output logic                  data_done,
    output logic [31:0]           data_rdata,
    output mem_bus_pkg::axi_ar_t   ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  mem_bus_pkg::axi_r_t    r,
    input  logic                  rvalid,
    output logic                  rready,
    output mem_bus_pkg::axi_aw_t   aw,
    output logic                  awvalid,
    input  logic                  awready,
    output mem_bus_pkg::axi_w_t    w,
    output logic                  wvalid,
    input  logic                  wready,
    input  mem_bus_pkg::axi_b_t    b,
    input  logic                  bvalid,
    output logic                  bready
);

    mem_bus_pkg::axi_ar_t inst_ar;
    mem_bus_pkg::axi_ar_t data_ar;
    logic inst_arvalid;
    logic inst_arready;
    logic inst_rvalid;
    logic inst_rready;
    logic data_arvalid;
    logic data_arready;
    logic data_rvalid;
    logic data_rready;

    inst_fetch_master #(.INST_ID(INST_ID)) u_inst_fetch_master (
        .axi4_master(axi4_master), .rst(rst),
        .fetch_en(fetch_en), .fetch_addr(fetch_addr), .fetch_cancel(fetch_cancel),
        .fetch_valid(fetch_valid), .fetch_data(fetch_data),
        .ar(inst_ar), .arvalid(inst_arvalid), .arready(inst_arready),
        .r(r), .rvalid(inst_rvalid), .rready(inst_rready)
    );

    // writes bypass the arbiter and go straight to the external port
    data_access_master #(.DATA_ID(DATA_ID)) u_data_access_master (
        .axi4_master(axi4_master), .rst(rst),
        .data_en(data_en), .data_req(data_req),
        .data_done(data_done), .data_rdata(data_rdata),
        .ar(data_ar), .arvalid(data_arvalid), .arready(data_arready),
        .r(r), .rvalid(data_rvalid), .rready(data_rready),
        .aw(aw), .awvalid(awvalid), .awready(awready),
        .w(w), .wvalid(wvalid), .wready(wready),
        .b(b), .bvalid(bvalid), .bready(bready)
    );

    axi_read_arbiter #(.INST_ID(INST_ID), .DATA_ID(DATA_ID)) u_axi_read_arbiter (
        .axi4_master(axi4_master), .rst(rst),
        .inst_ar(inst_ar), .inst_arvalid(inst_arvalid), .inst_arready(inst_arready),
        .data_ar(data_ar), .data_arvalid(data_arvalid), .data_arready(data_arready),
        .m_ar(ar), .m_arvalid(arvalid), .m_arready(arready),
        .inst_rready(inst_rready), .data_rready(data_rready),
        .m_rvalid(rvalid), .m_r(r), .m_rready(rready),
        .inst_rvalid(inst_rvalid), .data_rvalid(data_rvalid)
    );

endmodule

//--- testbench/mem_bus_chk.sv
`timescale 1ns/1ps

module mem_bus_chk (
    input logic        axi4_master,
    input logic        rst,
    input logic        a_valid,
    input logic        a_ready,
    input logic [71:0] a_payload,
    input logic        b_valid,
    input logic        b_ready,
    input logic [71:0] b_payload,
    input logic        pulse,
    input logic        r_valid,
    input logic        route_inst,
    input logic        route_data
);

    // a stalled channel keeps valid up and its payload unchanged
    a_held: assert property (@(posedge axi4_master) disable iff (rst)
        a_valid && !a_ready |=> a_valid && $stable(a_payload))
        else $error("first channel dropped valid or changed payload while stalled");

    b_held: assert property (@(posedge axi4_master) disable iff (rst)
        b_valid && !b_ready |=> b_valid && $stable(b_payload))
        else $error("second channel dropped valid or changed payload while stalled");

    pulse_once: assert property (@(posedge axi4_master) disable iff (rst)
        pulse |=> !pulse)
        else $error("processor-side pulse stayed high for two cycles");

    // an R beat goes to exactly one master
    route_single: assert property (@(posedge axi4_master) disable iff (rst)
        r_valid |-> (route_inst != route_data))
        else $error("R beat was not routed to exactly one master");

endmodule

bind axi_read_arbiter mem_bus_chk u_arb_chk (
    .axi4_master(axi4_master), .rst(rst),
    .a_valid(m_arvalid), .a_ready(m_arready), .a_payload({36'd0, m_ar}),
    .b_valid(data_arvalid), .b_ready(data_arready), .b_payload({36'd0, data_ar}),
    .pulse(1'b0), .r_valid(m_rvalid), .route_inst(inst_rvalid), .route_data(data_rvalid)
);

bind data_access_master mem_bus_chk u_data_chk (
    .axi4_master(axi4_master), .rst(rst),
    .a_valid(awvalid), .a_ready(awready), .a_payload({36'd0, aw}),
    .b_valid(wvalid), .b_ready(wready), .b_payload({35'd0, w}),
    .pulse(data_done), .r_valid(1'b0), .route_inst(1'b0), .route_data(1'b0)
);

bind inst_fetch_master mem_bus_chk u_fetch_chk (
    .axi4_master(axi4_master), .rst(rst),
    .a_valid(arvalid), .a_ready(arready), .a_payload({36'd0, ar}),
    .b_valid(1'b0), .b_ready(1'b0), .b_payload(72'd0),
    .pulse(fetch_valid), .r_valid(1'b0), .route_inst(1'b0), .route_data(1'b0)
);

//--- testbench/mem_bus_tb.sv
`timescale 1ns/1ps

module mem_bus_tb;

    localparam logic [3:0] INST_ID = 4'd0;
    localparam logic [3:0] DATA_ID = 4'd1;
    localparam int N_FETCH = 200;
    localparam int N_DATA = 200;
    localparam int CYCLE_LIMIT = (N_FETCH + N_DATA) * 40;

    logic                   axi4_master;
    logic                   rst;
    logic                   fetch_en;
    logic [31:0]            fetch_addr;
    logic                   fetch_cancel;
    logic                   fetch_valid;
    logic [31:0]            fetch_data;
    logic                   data_en;
    mem_bus_pkg::data_req_t data_req;
    logic                   data_done;
    logic [31:0]            data_rdata;
    mem_bus_pkg::axi_ar_t   ar;
    logic                   arvalid;
    logic                   arready;
    mem_bus_pkg::axi_r_t    r;
    logic                   rvalid;
    logic                   rready;
    mem_bus_pkg::axi_aw_t   aw;
    logic                   awvalid;
    logic                   awready;
    mem_bus_pkg::axi_w_t    w;
    logic                   wvalid;
    logic                   wready;
    mem_bus_pkg::axi_b_t    b;
    logic                   bvalid;
    logic                   bready;

    logic [31:0]         mem [0:255];     // slave storage
    logic [31:0]         shadow [0:255];  // reference model
    mem_bus_pkg::axi_r_t last_inst_r;
    mem_bus_pkg::axi_r_t last_data_r;
    mem_bus_pkg::axi_w_t last_w;
    int                  fetch_pulses;

    mem_bus_top #(.INST_ID(INST_ID), .DATA_ID(DATA_ID)) uut (
        .axi4_master(axi4_master), .rst(rst),
        .fetch_en(fetch_en), .fetch_addr(fetch_addr), .fetch_cancel(fetch_cancel),
        .fetch_valid(fetch_valid), .fetch_data(fetch_data),
        .data_en(data_en), .data_req(data_req), .data_done(data_done), .data_rdata(data_rdata),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .r(r), .rvalid(rvalid), .rready(rready),
        .aw(aw), .awvalid(awvalid), .awready(awready),
        .w(w), .wvalid(wvalid), .wready(wready),
        .b(b), .bvalid(bvalid), .bready(bready)
    );

    function automatic logic [31:0] initial_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a0000;
    endfunction

    function automatic logic [7:0] word_index(input logic [31:0] addr);
        return addr[9:2];
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] cur_word,
                                                input logic [31:0] wdata,
                                                input logic [3:0]  strb);
        logic [31:0] merged;
        merged = cur_word;
        for (int k = 0; k < 4; k++) begin
            if (strb[k]) begin
                merged[8*k +: 8] = wdata[8*k +: 8];
            end
        end
        return merged;
    endfunction

    // fetches stay in the lower half, data traffic in a small upper window
    function automatic logic [31:0] fetch_word_addr();
        return {22'd0, 8'($urandom_range(0, 127)), 2'b00};
    endfunction

    function automatic logic [31:0] data_word_addr();
        return 32'h200 + {26'd0, 4'($urandom_range(0, 15)), 2'b00};
    endfunction

    task automatic stop_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] expect_word);
        if (got !== expect_word) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, expect_word);
            stop_run();
        end
    endtask

    task automatic check_resp(input string what, input mem_bus_pkg::axi_r_t got,
                              input mem_bus_pkg::axi_r_t expect_beat);
        if (got !== expect_beat) begin
            $display("Mismatch at %0t: %s id %h data %h resp %h last %b, expected %h %h %h %b",
                     $time, what, got.id, got.data, got.resp, got.last, expect_beat.id,
                     expect_beat.data, expect_beat.resp, expect_beat.last);
            stop_run();
        end
    endtask

    task automatic check_wbeat(input string what, input mem_bus_pkg::axi_w_t got,
                               input mem_bus_pkg::axi_w_t expect_beat);
        if (got !== expect_beat) begin
            $display("Mismatch at %0t: %s data %h strb %h last %b, expected %h %h %b",
                     $time, what, got.data, got.strb, got.last, expect_beat.data,
                     expect_beat.strb, expect_beat.last);
            stop_run();
        end
    endtask

    task automatic check_grant(input string what, input logic [3:0] got,
                               input logic [3:0] expect_id);
        if (got !== expect_id) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, expect_id);
            stop_run();
        end
    endtask

    task automatic run_fetches(input int count);
        logic [31:0]         addr_now;
        logic [31:0]         expect_word;
        logic                want_cancel;
        logic                got_valid;
        int                  cancel_at;
        int                  waited;
        mem_bus_pkg::axi_r_t expect_beat;
        for (int n = 0; n < count; n++) begin
            addr_now    = fetch_word_addr();
            want_cancel = ($urandom_range(0, 3) == 0);
            cancel_at   = $urandom_range(1, 4);
            waited      = 0;
            got_valid   = 1'b0;
            @(posedge axi4_master);
            fetch_en   <= 1'b1;
            fetch_addr <= addr_now;
            while (!got_valid) begin
                @(posedge axi4_master);
                waited++;
                fetch_cancel <= 1'b0;
                if (fetch_valid) begin
                    got_valid = 1'b1;
                    fetch_en <= 1'b0;
                    expect_word = shadow[word_index(addr_now)];
                    expect_beat = '{id: INST_ID, data: expect_word, resp: 2'b00, last: 1'b1};
                    check_word("fetch_data", fetch_data, expect_word);
                    check_resp("fetch R beat", last_inst_r, expect_beat);
                end else if (want_cancel && waited >= cancel_at) begin
                    want_cancel = 1'b0;
                    // a beat landing on this edge is already delivered, so no cancel then
                    if (!(rvalid && rready && r.id == INST_ID)) begin
                        addr_now = fetch_word_addr();
                        fetch_cancel <= 1'b1;
                        fetch_addr   <= addr_now;
                    end
                end
            end
        end
    endtask

    task automatic run_data(input int count);
        mem_bus_pkg::data_req_t req;
        mem_bus_pkg::axi_r_t    expect_beat;
        mem_bus_pkg::axi_w_t    expect_w;
        logic [7:0]             idx;
        logic                   done_seen;
        for (int n = 0; n < count; n++) begin
            req.we    = 1'($urandom_range(0, 1));
            req.addr  = data_word_addr();
            req.wdata = $urandom();
            req.wstrb = 4'($urandom_range(0, 15));
            idx       = word_index(req.addr);
            done_seen = 1'b0;
            @(posedge axi4_master);
            data_en  <= 1'b1;
            data_req <= req;
            while (!done_seen) begin
                @(posedge axi4_master);
                done_seen = data_done;
            end
            data_en <= 1'b0;
            if (req.we) begin
                expect_w = '{data: req.wdata, strb: req.wstrb, last: 1'b1};
                check_wbeat("W beat", last_w, expect_w);
                shadow[idx] = merge_bytes(shadow[idx], req.wdata, req.wstrb);
            end else begin
                expect_beat = '{id: DATA_ID, data: shadow[idx], resp: 2'b00, last: 1'b1};
                check_word("data_rdata", data_rdata, shadow[idx]);
                check_resp("data R beat", last_data_r, expect_beat);
            end
        end
    endtask

    initial begin : clock_gen
        axi4_master = 1'b0;
        forever #50 axi4_master = ~axi4_master;
    end

    initial begin : main_sequence
        void'($urandom(32'hab4817f3));
        for (int i = 0; i < 256; i++) begin
            shadow[i] = initial_word({22'd0, 8'(i), 2'b00});
        end
        rst          = 1'b1;
        fetch_en     = 1'b0;
        fetch_addr   = 32'd0;
        fetch_cancel = 1'b0;
        data_en      = 1'b0;
        data_req     = '0;
        repeat (4) @(posedge axi4_master);
        rst <= 1'b0;
        fork
            run_fetches(N_FETCH);
            run_data(N_DATA);
        join
        repeat (4) @(posedge axi4_master);
        if (fetch_pulses != N_FETCH) begin
            $display("Wrong number of fetch_valid pulses: %0d for %0d fetches",
                     fetch_pulses, N_FETCH);
            stop_run();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

    // AXI slave with random ready and response delays, reads return in order
    initial begin : axi_slave
        mem_bus_pkg::axi_ar_t rd_q[$];
        mem_bus_pkg::axi_ar_t rd_req;
        mem_bus_pkg::axi_aw_t aw_hold;
        mem_bus_pkg::axi_w_t  w_hold;
        logic                 aw_got;
        logic                 w_got;
        logic                 b_pend;
        int                   rd_wait;
        int                   b_wait;
        for (int i = 0; i < 256; i++) begin
            mem[i] = initial_word({22'd0, 8'(i), 2'b00});
        end
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        rvalid  = 1'b0;
        bvalid  = 1'b0;
        r       = '0;
        b       = '0;
        aw_got  = 1'b0;
        w_got   = 1'b0;
        b_pend  = 1'b0;
        rd_wait = 0;
        b_wait  = 0;
        forever begin
            @(posedge axi4_master);
            if (!rst) begin
                if (arvalid && arready) begin
                    rd_q.push_back(ar);
                end
                if (awvalid && awready) begin
                    aw_hold = aw;
                    aw_got  = 1'b1;
                end
                if (wvalid && wready) begin
                    w_hold = w;
                    last_w = w;
                    w_got  = 1'b1;
                end
                arready <= ($urandom_range(0, 3) != 0);
                awready <= ($urandom_range(0, 2) != 0);
                wready  <= ($urandom_range(0, 2) != 0);
                if (rvalid && rready) begin
                    if (r.id == INST_ID) begin
                        last_inst_r = r;
                    end else begin
                        last_data_r = r;
                    end
                    rvalid <= 1'b0;
                end else if (!rvalid && rd_q.size() > 0) begin
                    if (rd_wait > 0) begin
                        rd_wait--;
                    end else begin
                        rd_req = rd_q.pop_front();
                        r <= '{id: rd_req.id, data: mem[word_index(rd_req.addr)],
                               resp: 2'b00, last: 1'b1};
                        rvalid <= 1'b1;
                        rd_wait = $urandom_range(0, 5);
                    end
                end
                if (bvalid && bready) begin
                    bvalid <= 1'b0;
                end else if (b_pend && !bvalid) begin
                    if (b_wait > 0) begin
                        b_wait--;
                    end else begin
                        b      <= '{id: aw_hold.id, resp: 2'b00};
                        bvalid <= 1'b1;
                        b_pend = 1'b0;
                    end
                end
                if (aw_got && w_got && !b_pend) begin
                    mem[word_index(aw_hold.addr)] = merge_bytes(mem[word_index(aw_hold.addr)],
                                                                w_hold.data, w_hold.strb);
                    aw_got = 1'b0;
                    w_got  = 1'b0;
                    b_pend = 1'b1;
                    b_wait = $urandom_range(0, 5);
                end
            end
        end
    end

    // round-robin grant model with its lock, and a count of grants one port
    // gets while the other is left waiting
    initial begin : grant_monitor
        int   inst_skips;
        int   data_skips;
        logic owned;
        logic owner_data;
        logic tie_to_data;
        inst_skips  = 0;
        data_skips  = 0;
        owned       = 1'b0;
        owner_data  = 1'b0;
        tie_to_data = 1'b0;
        forever begin
            @(posedge axi4_master);
            if (!rst && arvalid) begin
                if (!owned) begin
                    owned      = 1'b1;  // the grant holds from its first valid cycle
                    owner_data = (uut.inst_arvalid && uut.data_arvalid) ? tie_to_data
                                                                        : uut.data_arvalid;
                end
                check_grant("AR grant id", ar.id, owner_data ? DATA_ID : INST_ID);
            end
            if (!rst && arvalid && arready) begin
                owned       = 1'b0;
                tie_to_data = !owner_data;
                if (ar.id == INST_ID) begin
                    inst_skips = 0;
                    if (uut.data_arvalid) data_skips++;
                end else begin
                    data_skips = 0;
                    if (uut.inst_arvalid) inst_skips++;
                end
                if (inst_skips > 2 || data_skips > 2) begin
                    $display("Arbiter left one port waiting through three grants at %0t", $time);
                    stop_run();
                end
            end
        end
    end

    initial begin : fetch_pulse_count
        fetch_pulses = 0;
        forever begin
            @(posedge axi4_master);
            if (!rst && fetch_valid) fetch_pulses++;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge axi4_master);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        stop_run();
    end

endmodule

//--- build.f
design/mem_bus_pkg.sv
design/inst_fetch_master.sv
design/data_access_master.sv
design/axi_read_arbiter.sv
design/mem_bus_top.sv
testbench/mem_bus_chk.sv
testbench/mem_bus_tb.sv

//--- Makefile
TOP := mem_bus_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -Mdir obj_dir -f build.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log || (echo "simulation ended without a verdict"; exit 1)

clean:
	rm -rf obj_dir sim.log
